//--- flist.f
+incdir+dv
source/ao_timer_pkg.sv
source/ao_reg_decoder.sv
source/ao_timer.sv
source/ao_rsp_collector.sv
source/ao_timer_subsystem.sv
dv/ao_timer_subsystem_tb.sv

//--- Makefile
# Verilator build and run for the always-on timer subsystem

VERILATOR ?= verilator
TOP       ?= ao_timer_subsystem_tb
FLIST     ?= flist.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -j 0

FAIL_MSG  := Checks failed
PASS_MSG  := All checks passed

SOURCES   := $(wildcard source/*.sv) $(wildcard dv/*.sv) $(wildcard dv/*.svh)
SIM_BIN   := $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM_BIN)

$(SIM_BIN): $(FLIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FLIST)

# The log decides the result, the simulator status is not used
run: compile
	@./$(SIM_BIN) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then \
	  echo "Simulation FAILED, see $(LOG)"; \
	  exit 1; \
	elif ! grep -q "$(PASS_MSG)" $(LOG); then \
	  echo "Simulation ended without a result, see $(LOG)"; \
	  exit 1; \
	else \
	  echo "Simulation passed"; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- dv/ao_tb_checks.svh
// ######################################
// AO timer testbench compare tasks
// Response and interrupt vector checks
// ######################################

`ifndef AO_TB_CHECKS_SVH
`define AO_TB_CHECKS_SVH

// Full response compare including valid and error
task automatic check_rsp(input ao_timer_pkg::reg_rsp_t got,
                         input ao_timer_pkg::reg_rsp_t exp,
                         input string                  msg);
  if (got !== exp) begin
    $display("CHECK FAILED at %0t: %s response valid=%0b error=%0b rdata=%08h",
             $time, msg, got.valid, got.error, got.rdata);
    $display("  expected valid=%0b error=%0b rdata=%08h",
             exp.valid, exp.error, exp.rdata);
    $display("Checks failed");
    $fatal(1, "Stopping at the first mismatch");
  end
endtask

// Interrupt vector plus its OR reduction
task automatic check_irq(input logic [NUM_TIMERS-1:0] got,
                         input logic                  got_any,
                         input logic [NUM_TIMERS-1:0] exp,
                         input string                 msg);
  if (got !== exp || got_any !== (|exp)) begin
    $display("CHECK FAILED at %0t: %s irq=%b irq_any=%0b, expected irq=%b irq_any=%0b",
             $time, msg, got, got_any, exp, |exp);
    $display("Checks failed");
    $fatal(1, "Stopping at the first mismatch");
  end
endtask

`endif

//--- dv/ao_timer_subsystem_tb.sv
// ######################################
// AO timer subsystem testbench
// Table driven register bus and IRQ test
// ######################################

`timescale 1ns/1ps

module ao_timer_subsystem_tb;

  localparam int unsigned NUM_TIMERS = 4;
  localparam int unsigned CLK_HALF   = 10;
  localparam logic [31:0] SEED       = 32'd62121;

  typedef struct packed {
    logic                   is_wait;
    logic                   chk_irq;
    logic [15:0]            cycles;
    ao_timer_pkg::reg_req_t req;
    ao_timer_pkg::reg_rsp_t exp_rsp;
    logic [NUM_TIMERS-1:0]  exp_irq;
  } entry_t;

  logic                   clk_i;
  logic                   arst_n_i;
  ao_timer_pkg::reg_req_t req_i;
  ao_timer_pkg::reg_rsp_t rsp_o;
  logic [NUM_TIMERS-1:0]  irq_o;
  logic                   irq_any_o;

  entry_t                 table_q[$];
  string                  label_q[$];
  logic [31:0]            rng_state = SEED;
  logic [31:0]            exp_count [NUM_TIMERS];
  logic [31:0]            exp_compare [NUM_TIMERS];
  logic [NUM_TIMERS-1:0]  cur_irq;
  logic                   irq_chk_on;
  int unsigned            cycle_count = 0;
  int unsigned            cycle_limit = 0;

  // Expected result of the request one cycle back
  ao_timer_pkg::reg_rsp_t prev_rsp;
  logic [NUM_TIMERS-1:0]  prev_irq;
  logic                   prev_chk;
  string                  prev_label;

  `include "ao_tb_checks.svh"

  ao_timer_subsystem #(
    .NUM_TIMERS(NUM_TIMERS)
  ) uut (
    .clk_i    (clk_i),
    .arst_n_i (arst_n_i),
    .req_i    (req_i),
    .rsp_o    (rsp_o),
    .irq_o    (irq_o),
    .irq_any_o(irq_any_o)
  );

  initial begin
    clk_i = 1'b0;
    forever #CLK_HALF clk_i = ~clk_i;
  end

  always @(posedge clk_i) begin
    cycle_count <= cycle_count + 1;
    if (cycle_limit != 0 && cycle_count >= cycle_limit) begin
      $display("Run timed out after %0d cycles without finishing the table", cycle_count);
      $display("Checks failed");
      $fatal(1, "Timeout");
    end
  end

  function automatic logic [31:0] next_random();
    logic [31:0] x;
    x = rng_state;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    rng_state = x;
    return x;
  endfunction

  function automatic logic [7:0] make_addr(input int unsigned idx, input logic [1:0] off);
    return {4'(idx), off, 2'b00};
  endfunction

  // Out of range index answers with error and zero data
  function automatic void add_access(input logic        write,
                                     input int unsigned idx,
                                     input logic [1:0]  off,
                                     input logic [31:0] wdata,
                                     input logic [31:0] rdata,
                                     input string       label);
    entry_t e;
    logic   err;
    err = (idx >= NUM_TIMERS);
    e = '0;
    e.chk_irq = irq_chk_on;
    e.exp_irq = cur_irq;
    e.req = '{valid: 1'b1, write: write, addr: make_addr(idx, off), wdata: wdata};
    e.exp_rsp = '{valid: 1'b1, error: err, rdata: (err || write) ? 32'd0 : rdata};
    table_q.push_back(e);
    label_q.push_back($sformatf("%s t%0d reg %0d", label, idx, off));
  endfunction

  function automatic void add_write(input int unsigned idx, input logic [1:0] off,
                                    input logic [31:0] data);
    add_access(1'b1, idx, off, data, 32'd0, "write");
  endfunction

  function automatic void add_read(input int unsigned idx, input logic [1:0] off,
                                   input logic [31:0] data);
    add_access(1'b0, idx, off, 32'd0, data, "read");
  endfunction

  function automatic void add_wait(input int unsigned n);
    entry_t e;
    e = '0;
    e.is_wait = 1'b1;
    e.cycles  = 16'(n);
    table_q.push_back(e);
    label_q.push_back($sformatf("wait %0d cycles", n));
  endfunction

  function automatic void build_table();
    logic [31:0] cmp;
    logic [31:0] data;
    cur_irq    = '0;
    irq_chk_on = 1'b1;
    // Reset values
    for (int t = 0; t < NUM_TIMERS; t++) begin
      for (int r = 0; r < 4; r++) begin
        add_read(t, 2'(r), 32'd0);
      end
    end
    // Random COUNT and COMPARE with the timers stopped
    for (int t = 0; t < NUM_TIMERS; t++) begin
      exp_count[t]   = next_random();
      exp_compare[t] = next_random();
      add_write(t, ao_timer_pkg::REG_COUNT, exp_count[t]);
      add_write(t, ao_timer_pkg::REG_COMPARE, exp_compare[t]);
    end
    for (int t = 0; t < NUM_TIMERS; t++) begin
      add_read(t, ao_timer_pkg::REG_COUNT, exp_count[t]);
      add_read(t, ao_timer_pkg::REG_COMPARE, exp_compare[t]);
      add_read(t, ao_timer_pkg::REG_CTRL, 32'd0);
      add_read(t, ao_timer_pkg::REG_STATUS, 32'd0);
    end
    // Indices past the last timer
    for (int idx = NUM_TIMERS; idx < 16; idx++) begin
      add_write(idx, ao_timer_pkg::REG_COMPARE, next_random());
      add_read(idx, 2'(idx % 4), 32'd0);
    end
    for (int t = 0; t < NUM_TIMERS; t++) begin
      add_read(t, ao_timer_pkg::REG_COUNT, exp_count[t]);
      add_read(t, ao_timer_pkg::REG_COMPARE, exp_compare[t]);
    end
    // Mixed burst with one request per cycle
    data = next_random();
    add_read(2, ao_timer_pkg::REG_COUNT, exp_count[2]);
    add_read(NUM_TIMERS, ao_timer_pkg::REG_CTRL, 32'd0);
    add_write(3, ao_timer_pkg::REG_COMPARE, data);
    add_read(3, ao_timer_pkg::REG_COMPARE, data);
    add_write(NUM_TIMERS + 1, ao_timer_pkg::REG_STATUS, 32'd1);
    add_read(1, ao_timer_pkg::REG_COMPARE, exp_compare[1]);
    // Expiry with timer 1 running without its interrupt
    cmp = 32'd4 + (next_random() % 32'd8);
    add_write(0, ao_timer_pkg::REG_COUNT, 32'd0);
    add_write(0, ao_timer_pkg::REG_COMPARE, cmp);
    add_write(1, ao_timer_pkg::REG_COUNT, 32'd0);
    add_write(1, ao_timer_pkg::REG_COMPARE, cmp);
    add_write(0, ao_timer_pkg::REG_CTRL, 32'd3);
    add_write(1, ao_timer_pkg::REG_CTRL, 32'd1);
    irq_chk_on = 1'b0;
    add_wait(int'(cmp) + 6);
    irq_chk_on = 1'b1;
    cur_irq    = 4'b0001;
    add_read(0, ao_timer_pkg::REG_STATUS, 32'd1);
    add_read(1, ao_timer_pkg::REG_STATUS, 32'd1);
    add_read(0, ao_timer_pkg::REG_CTRL, 32'd3);
    add_read(1, ao_timer_pkg::REG_CTRL, 32'd1);
    // Stop timer 0 with its irq enable kept and clear it
    add_write(0, ao_timer_pkg::REG_CTRL, 32'd2);
    cur_irq = '0;
    add_write(0, ao_timer_pkg::REG_STATUS, 32'd1);
    add_read(0, ao_timer_pkg::REG_STATUS, 32'd0);
    add_read(0, ao_timer_pkg::REG_CTRL, 32'd2);
    add_write(1, ao_timer_pkg::REG_CTRL, 32'd0);
    add_read(1, ao_timer_pkg::REG_STATUS, 32'd1);
    add_write(1, ao_timer_pkg::REG_STATUS, 32'd1);
    add_read(1, ao_timer_pkg::REG_STATUS, 32'd0);
    add_wait(2);
  endfunction

  // Drive one slot and check the response of the slot before
  task automatic apply_slot(input ao_timer_pkg::reg_req_t req,
                            input ao_timer_pkg::reg_rsp_t exp_rsp,
                            input logic [NUM_TIMERS-1:0]  exp_irq,
                            input logic                   chk_irq,
                            input string                  label);
    @(posedge clk_i);
    req_i <= req;
    @(negedge clk_i);
    check_rsp(rsp_o, prev_rsp, prev_label);
    if (prev_chk) begin
      check_irq(irq_o, irq_any_o, prev_irq, prev_label);
    end
    prev_rsp   = exp_rsp;
    prev_irq   = exp_irq;
    prev_chk   = chk_irq;
    prev_label = label;
  endtask

  initial begin
    int unsigned total;
    req_i    <= '0;
    arst_n_i <= 1'b0;
    build_table();
    total = 0;
    foreach (table_q[i]) begin
      total += table_q[i].is_wait ? int'(table_q[i].cycles) : 1;
    end
    cycle_limit = total + 50;
    prev_rsp   = '0;
    prev_irq   = '0;
    prev_chk   = 1'b1;
    prev_label = "idle after reset";
    repeat (3) @(posedge clk_i);
    arst_n_i <= 1'b1;
    foreach (table_q[i]) begin
      if (table_q[i].is_wait) begin
        repeat (table_q[i].cycles) begin
          apply_slot('0, '0, '0, 1'b0, label_q[i]);
        end
      end else begin
        apply_slot(table_q[i].req, table_q[i].exp_rsp, table_q[i].exp_irq,
                   table_q[i].chk_irq, label_q[i]);
      end
    end
    $display("All checks passed");
    $finish;
  end

endmodule : ao_timer_subsystem_tb

//--- source/ao_timer_subsystem.sv
// ######################################
// AO timer subsystem top level
// Decoder, timer array, response merge
// ######################################

`timescale 1ns/1ps

module ao_timer_subsystem #(
  parameter int unsigned NUM_TIMERS = 4
) (
  input  logic                   clk_i,
  input  logic                   arst_n_i,
  input  ao_timer_pkg::reg_req_t req_i,
  output ao_timer_pkg::reg_rsp_t rsp_o,
  output logic [NUM_TIMERS-1:0]  irq_o,
  output logic                   irq_any_o
);

  logic [NUM_TIMERS-1:0]  tmr_sel;
  logic                   dec_err;
  ao_timer_pkg::reg_rsp_t tmr_rsp [NUM_TIMERS];
  logic [NUM_TIMERS-1:0]  tmr_irq;

  ao_reg_decoder #(
    .NUM_TIMERS(NUM_TIMERS)
  ) ao_reg_decoder_i (
    .req_i    (req_i),
    .sel_o    (tmr_sel),
    .dec_err_o(dec_err)
  );

  // All timers see the common request and only the selected one acts
  generate
    for (genvar i = 0; i < NUM_TIMERS; i++) begin : gen_timers
      ao_timer ao_timer_i (
        .clk_i   (clk_i),
        .arst_n_i(arst_n_i),
        .req_i   (req_i),
        .sel_i   (tmr_sel[i]),
        .rsp_o   (tmr_rsp[i]),
        .irq_o   (tmr_irq[i])
      );
    end
  endgenerate

  ao_rsp_collector #(
    .NUM_TIMERS(NUM_TIMERS)
  ) ao_rsp_collector_i (
    .clk_i    (clk_i),
    .arst_n_i (arst_n_i),
    .dec_err_i(dec_err),
    .tmr_rsp_i(tmr_rsp),
    .tmr_irq_i(tmr_irq),
    .rsp_o    (rsp_o),
    .irq_o    (irq_o),
    .irq_any_o(irq_any_o)
  );

endmodule : ao_timer_subsystem

//--- source/ao_rsp_collector.sv
// ######################################
// AO response collector
// Merges timer responses and interrupts
// ######################################

`timescale 1ns/1ps

module ao_rsp_collector #(
  parameter int unsigned NUM_TIMERS = 4
) (
  input  logic                   clk_i,
  input  logic                   arst_n_i,
  input  logic                   dec_err_i,
  input  ao_timer_pkg::reg_rsp_t tmr_rsp_i [NUM_TIMERS],
  input  logic [NUM_TIMERS-1:0]  tmr_irq_i,
  output ao_timer_pkg::reg_rsp_t rsp_o,
  output logic [NUM_TIMERS-1:0]  irq_o,
  output logic                   irq_any_o
);

  logic                   err_q;
  ao_timer_pkg::reg_rsp_t merged;

  // Error response lines up with the registered timer responses
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      err_q <= 1'b0;
    end else begin
      err_q <= dec_err_i;
    end
  end

  // At most one source is valid per cycle and idle ones drive zero
  always_comb begin
    merged = '{valid: err_q, error: err_q, rdata: '0};
    for (int i = 0; i < NUM_TIMERS; i++) begin
      merged = ao_timer_pkg::reg_rsp_t'(merged | tmr_rsp_i[i]);
    end
  end

  assign rsp_o = merged;

  assign irq_o     = tmr_irq_i;
  assign irq_any_o = |tmr_irq_i;

endmodule : ao_rsp_collector

//--- source/ao_timer.sv
// ######################################
// AO timer slave
// Counter, compare, sticky expiry, regs
// ######################################

`timescale 1ns/1ps

module ao_timer (
  input  logic                   clk_i,
  input  logic                   arst_n_i,
  input  ao_timer_pkg::reg_req_t req_i,
  input  logic                   sel_i,
  output ao_timer_pkg::reg_rsp_t rsp_o,
  output logic                   irq_o
);

  logic [ao_timer_pkg::REG_W-1:0]  reg_off;
  logic                            wr_en;
  logic                            rd_en;
  logic                            hit;

  logic                            enable_q;
  logic                            irq_en_q;
  logic                            expired_q;
  logic                            expired_d;
  logic [ao_timer_pkg::DATA_W-1:0] count_q;
  logic [ao_timer_pkg::DATA_W-1:0] count_d;
  logic [ao_timer_pkg::DATA_W-1:0] compare_q;

  logic [ao_timer_pkg::DATA_W-1:0] rdata_mux;
  logic [ao_timer_pkg::DATA_W-1:0] rsp_rdata_q;
  logic                            rsp_valid_q;

  assign reg_off = req_i.addr[ao_timer_pkg::IDX_LSB-1:ao_timer_pkg::REG_LSB];
  assign wr_en   = sel_i && req_i.write;
  assign rd_en   = sel_i && !req_i.write;

  // Compare match only counts while running
  assign hit = enable_q && (count_q == compare_q);

  always_comb begin
    count_d = count_q;
    if (wr_en && reg_off == ao_timer_pkg::REG_COUNT) begin
      count_d = req_i.wdata;
    end else if (hit) begin
      count_d = '0;
    end else if (enable_q) begin
      count_d = count_q + 1'b1;
    end
  end

  // Sticky W1C flag where a fresh expiry beats the clear
  always_comb begin
    expired_d = expired_q;
    if (hit) begin
      expired_d = 1'b1;
    end else if (wr_en && reg_off == ao_timer_pkg::REG_STATUS && req_i.wdata[0]) begin
      expired_d = 1'b0;
    end
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      enable_q  <= 1'b0;
      irq_en_q  <= 1'b0;
      compare_q <= '0;
    end else if (wr_en) begin
      if (reg_off == ao_timer_pkg::REG_CTRL) begin
        enable_q <= req_i.wdata[ao_timer_pkg::CTRL_ENABLE_BIT];
        irq_en_q <= req_i.wdata[ao_timer_pkg::CTRL_IRQ_EN_BIT];
      end
      if (reg_off == ao_timer_pkg::REG_COMPARE) begin
        compare_q <= req_i.wdata;
      end
    end
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      count_q   <= '0;
      expired_q <= 1'b0;
    end else begin
      count_q   <= count_d;
      expired_q <= expired_d;
    end
  end

  // Read mux sees the values before this cycle's write
  always_comb begin
    rdata_mux = '0;
    case (reg_off)
      ao_timer_pkg::REG_CTRL: begin
        rdata_mux[ao_timer_pkg::CTRL_ENABLE_BIT] = enable_q;
        rdata_mux[ao_timer_pkg::CTRL_IRQ_EN_BIT] = irq_en_q;
      end
      ao_timer_pkg::REG_COUNT:   rdata_mux = count_q;
      ao_timer_pkg::REG_COMPARE: rdata_mux = compare_q;
      ao_timer_pkg::REG_STATUS:  rdata_mux[0] = expired_q;
    endcase
  end

  // Zero data when idle so the collector can OR
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      rsp_valid_q <= 1'b0;
      rsp_rdata_q <= '0;
    end else begin
      rsp_valid_q <= sel_i;
      rsp_rdata_q <= rd_en ? rdata_mux : '0;
    end
  end

  assign rsp_o = '{valid: rsp_valid_q, error: 1'b0, rdata: rsp_rdata_q};

  assign irq_o = expired_q && irq_en_q;

endmodule : ao_timer

//--- source/ao_reg_decoder.sv
// ######################################
// AO register bus decoder
// Index field to one-hot timer select
// ######################################

`timescale 1ns/1ps

module ao_reg_decoder #(
  parameter int unsigned NUM_TIMERS = 4
) (
  input  ao_timer_pkg::reg_req_t  req_i,
  output logic [NUM_TIMERS-1:0]   sel_o,
  output logic                    dec_err_o
);

  logic [ao_timer_pkg::IDX_W-1:0] idx;
  logic                           in_range;

  assign idx = req_i.addr[ao_timer_pkg::ADDR_W-1:ao_timer_pkg::IDX_LSB];

  // Only place where the index range is tested
  assign in_range = (int'(idx) < NUM_TIMERS);

  generate
    for (genvar i = 0; i < NUM_TIMERS; i++) begin : gen_sel
      assign sel_o[i] = req_i.valid && in_range &&
                        (idx == ao_timer_pkg::IDX_W'(i));
    end
  endgenerate

  // Collector answers an out of range index with an error
  assign dec_err_o = req_i.valid && !in_range;

endmodule : ao_reg_decoder

//--- source/ao_timer_pkg.sv
// ######################################
// Always-on timer shared definitions
// Bus structs, register map, address split
// ######################################

package ao_timer_pkg;

  localparam int unsigned ADDR_W = 8;
  localparam int unsigned DATA_W = 32;

  // Timer index in addr[7:4] and register word in addr[3:2]
  localparam int unsigned REG_LSB = 2;
  localparam int unsigned IDX_LSB = 4;
  localparam int unsigned REG_W   = IDX_LSB - REG_LSB;
  localparam int unsigned IDX_W   = ADDR_W - IDX_LSB;

  // Register word offsets
  localparam logic [REG_W-1:0] REG_CTRL    = 2'd0;
  localparam logic [REG_W-1:0] REG_COUNT   = 2'd1;
  localparam logic [REG_W-1:0] REG_COMPARE = 2'd2;
  localparam logic [REG_W-1:0] REG_STATUS  = 2'd3;

  // CTRL fields
  localparam int unsigned CTRL_ENABLE_BIT = 0;
  localparam int unsigned CTRL_IRQ_EN_BIT = 1;

  // Single-cycle request strobe
  typedef struct packed {
    logic              valid;
    logic              write;
    logic [ADDR_W-1:0] addr;
    logic [DATA_W-1:0] wdata;
  } reg_req_t;

  // Response one cycle after the request
  typedef struct packed {
    logic              valid;
    logic              error;
    logic [DATA_W-1:0] rdata;
  } reg_rsp_t;

endpackage : ao_timer_pkg
